// ==== logic/rv32_exec_pkg.sv ====
`default_nettype none

package rv32_exec_pkg;

    // Datapath sizing
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int PC_STEP    = 4;

    // funct3 codes shared by the IMMED and REGREG groups
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // SYSTEM privileged encodings, selected by funct3 zero
    localparam logic [2:0]  F3_PRIV     = 3'b000;
    localparam logic [11:0] PRIV_ECALL  = 12'h000;
    localparam logic [11:0] PRIV_EBREAK = 12'h001;
    localparam logic [11:0] PRIV_WFI    = 12'h105;
    localparam logic [11:0] PRIV_MRET   = 12'h302;

    // funct7 of the M extension
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_e;

    // Encoded as funct3 of the multiply group
    typedef enum logic [1:0] {
        M_MUL    = 2'd0,
        M_MULH   = 2'd1,
        M_MULHSU = 2'd2,
        M_MULHU  = 2'd3
    } m_op_e;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_e;
    typedef enum logic       {B_RS2, B_IMM} b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_LINK, WB_IMM} wb_sel_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0]           imm11_00;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } itype_t;

    typedef struct packed {
        logic [6:0]            imm11_05;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm04_00;
        opcode_e               opcode;
    } stype_t;

    typedef struct packed {
        logic [19:0]           imm31_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } utype_t;

    // Side flags, common to decode and retire
    typedef struct packed {
        logic branch;
        logic jump;
        logic load;
        logic store;
        logic csr;
        logic ecall;
        logic ebreak;
        logic mret;
        logic wfi;
        logic illegal;
    } flags_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        alu_op_e               alu_op;
        a_sel_e                a_sel;
        b_sel_e                b_sel;
        wb_sel_e               wb_sel;
        logic                  m_valid;
        m_op_e                 m_op;
        logic                  wen;
        flags_t                flags;
    } decode_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       wdata;
        flags_t                flags;
    } retire_t;

endpackage

`default_nettype wire

// ==== logic/control_unit.sv ====
`default_nettype none

module control_unit (
    input  logic [31:0]            instr_i,
    input  logic                   m_claim_i,
    input  rv32_exec_pkg::m_op_e   m_op_i,
    output rv32_exec_pkg::decode_t dec_o
);
    import rv32_exec_pkg::*;

    rtype_t fmt_r;
    itype_t fmt_i;
    stype_t fmt_s;
    utype_t fmt_u;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    alu_op_e arith_op;
    logic    reg_form;
    logic    maybe_illegal;

    assign fmt_r = rtype_t'(instr_i);
    assign fmt_i = itype_t'(instr_i);
    assign fmt_s = stype_t'(instr_i);
    assign fmt_u = utype_t'(instr_i);

    // Sign-extended immediates of every format
    assign imm_i = {{(XLEN-12){fmt_i.imm11_00[11]}}, fmt_i.imm11_00};
    assign imm_s = {{(XLEN-12){fmt_s.imm11_05[6]}}, fmt_s.imm11_05, fmt_s.imm04_00};
    // B format reuses the S fields with bit 7 moved up to bit 11
    assign imm_b = {
        {(XLEN-13){fmt_s.imm11_05[6]}}, fmt_s.imm11_05[6], fmt_s.imm04_00[0],
        fmt_s.imm11_05[5:0], fmt_s.imm04_00[4:1], 1'b0
    };
    assign imm_u = {fmt_u.imm31_12, 12'b0};
    // J format reuses the U field, scrambled
    assign imm_j = {
        {(XLEN-21){fmt_u.imm31_12[19]}}, fmt_u.imm31_12[19], fmt_u.imm31_12[7:0],
        fmt_u.imm31_12[8], fmt_u.imm31_12[18:9], 1'b0
    };

    assign reg_form = (fmt_r.opcode == REGREG);

    // ALU operation for the IMMED and REGREG groups
    always_comb begin
        arith_op = ALU_ADD;
        case (fmt_r.funct3)
            F3_ADD:  arith_op = (reg_form && instr_i[30]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  arith_op = ALU_SLL;
            F3_SLT:  arith_op = ALU_SLT;
            F3_SLTU: arith_op = ALU_SLTU;
            F3_XOR:  arith_op = ALU_XOR;
            F3_SR:   arith_op = instr_i[30] ? ALU_SRA : ALU_SRL;
            F3_OR:   arith_op = ALU_OR;
            F3_AND:  arith_op = ALU_AND;
            default: arith_op = ALU_ADD;
        endcase
    end

    always_comb begin
        dec_o         = '0;
        maybe_illegal = 1'b0;
        dec_o.rs1     = fmt_r.rs1;
        dec_o.rs2     = fmt_r.rs2;
        dec_o.rd      = fmt_r.rd;
        dec_o.imm     = imm_i;
        dec_o.alu_op  = ALU_ADD;
        dec_o.a_sel   = A_RS1;
        dec_o.b_sel   = B_IMM;
        dec_o.wb_sel  = WB_ALU;
        dec_o.m_valid = m_claim_i;
        dec_o.m_op    = m_op_i;

        case (fmt_r.opcode)
            LUI: begin
                dec_o.imm    = imm_u;
                dec_o.a_sel  = A_ZERO;
                dec_o.wb_sel = WB_IMM;
                dec_o.wen    = 1'b1;
            end
            AUIPC: begin
                dec_o.imm   = imm_u;
                dec_o.a_sel = A_PC;
                dec_o.wen   = 1'b1;
            end
            JAL: begin
                // ALU forms the target, write-back takes the link value
                dec_o.imm        = imm_j;
                dec_o.a_sel      = A_PC;
                dec_o.wb_sel     = WB_LINK;
                dec_o.wen        = 1'b1;
                dec_o.flags.jump = 1'b1;
            end
            JALR: begin
                dec_o.wb_sel     = WB_LINK;
                dec_o.wen        = 1'b1;
                dec_o.flags.jump = 1'b1;
            end
            BRANCH: begin
                dec_o.imm          = imm_b;
                dec_o.b_sel        = B_RS2;
                dec_o.flags.branch = 1'b1;
            end
            LOAD: begin
                dec_o.wen        = 1'b1;
                dec_o.flags.load = 1'b1;
            end
            STORE: begin
                dec_o.imm         = imm_s;
                dec_o.flags.store = 1'b1;
            end
            IMMED: begin
                dec_o.alu_op = arith_op;
                dec_o.wen    = 1'b1;
            end
            REGREG: begin
                dec_o.alu_op  = arith_op;
                dec_o.b_sel   = B_RS2;
                // Unclaimed M encodings write nothing
                dec_o.wen     = !fmt_r.funct7[0] || m_claim_i;
                maybe_illegal = fmt_r.funct7[0];
            end
            MISCMEM: begin
                // Fences retire as no-ops
            end
            SYSTEM: begin
                if (fmt_i.funct3 == F3_PRIV) begin
                    case (fmt_i.imm11_00)
                        PRIV_ECALL:  dec_o.flags.ecall  = 1'b1;
                        PRIV_EBREAK: dec_o.flags.ebreak = 1'b1;
                        PRIV_MRET:   dec_o.flags.mret   = 1'b1;
                        PRIV_WFI:    dec_o.flags.wfi    = 1'b1;
                        default:     ;
                    endcase
                end else begin
                    dec_o.flags.csr = 1'b1;
                end
            end
            default: maybe_illegal = 1'b1;
        endcase

        // M extension overrides a funct7 mismatch
        dec_o.flags.illegal = maybe_illegal && !m_claim_i;
    end

    // Nothing undecodable may reach the register file
    a_illegal_no_wen: assert final (!(dec_o.flags.illegal && dec_o.wen))
        else $error("illegal instruction decoded with write enable");

endmodule

`default_nettype wire

// ==== logic/rv32m_decode.sv ====
`default_nettype none

module rv32m_decode (
    input  logic [31:0]          instr_i,
    output logic                 claim_o,
    output rv32_exec_pkg::m_op_e m_op_o
);
    import rv32_exec_pkg::*;

    rtype_t fmt_r;
    logic   is_muldiv;
    logic   is_mul;

    assign fmt_r = rtype_t'(instr_i);

    assign is_muldiv = (fmt_r.opcode == REGREG) && (fmt_r.funct7 == F7_MULDIV);

    // funct3 0..3 are the multiplies, 4..7 divide and remainder
    assign is_mul = !fmt_r.funct3[2];

    // Divide and remainder stay unclaimed
    assign claim_o = is_muldiv && is_mul;

    assign m_op_o = m_op_e'(fmt_r.funct3[1:0]);

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none

module reg_file (
    input  logic                                CLK,
    input  logic                                reset_i,
    input  logic [rv32_exec_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv32_exec_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv32_exec_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                                wen_i,
    input  logic [rv32_exec_pkg::XLEN-1:0]       wdata_i,
    output logic [rv32_exec_pkg::XLEN-1:0]       rdata1_o,
    output logic [rv32_exec_pkg::XLEN-1:0]       rdata2_o
);
    import rv32_exec_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // Combinational read ports
    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`default_nettype none

module alu (
    input  logic [rv32_exec_pkg::XLEN-1:0] a_i,
    input  logic [rv32_exec_pkg::XLEN-1:0] b_i,
    input  rv32_exec_pkg::alu_op_e          alu_op_i,
    input  logic                            m_valid_i,
    input  rv32_exec_pkg::m_op_e            m_op_i,
    output logic [rv32_exec_pkg::XLEN-1:0] result_o
);
    import rv32_exec_pkg::*;

    logic [4:0]        shamt;
    logic [XLEN-1:0]   alu_res;
    logic [XLEN-1:0]   mul_res;
    logic [2*XLEN-1:0] prod_ss;
    logic [2*XLEN-1:0] prod_su;
    logic [2*XLEN-1:0] prod_uu;

    assign shamt = b_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_res = a_i + b_i;
            ALU_SUB:  alu_res = a_i - b_i;
            ALU_SLL:  alu_res = a_i << shamt;
            ALU_SRL:  alu_res = a_i >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(a_i) >>> shamt);
            ALU_AND:  alu_res = a_i & b_i;
            ALU_OR:   alu_res = a_i | b_i;
            ALU_XOR:  alu_res = a_i ^ b_i;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, a_i < b_i};
            default:  alu_res = a_i + b_i;
        endcase
    end

    // Operands widened to 64 bits, low half of each product is exact
    assign prod_ss = {{XLEN{a_i[XLEN-1]}}, a_i} * {{XLEN{b_i[XLEN-1]}}, b_i};
    assign prod_su = {{XLEN{a_i[XLEN-1]}}, a_i} * {{XLEN{1'b0}}, b_i};
    assign prod_uu = {{XLEN{1'b0}}, a_i} * {{XLEN{1'b0}}, b_i};

    always_comb begin
        case (m_op_i)
            M_MUL:    mul_res = prod_uu[XLEN-1:0];
            M_MULH:   mul_res = prod_ss[2*XLEN-1:XLEN];
            M_MULHSU: mul_res = prod_su[2*XLEN-1:XLEN];
            M_MULHU:  mul_res = prod_uu[2*XLEN-1:XLEN];
            default:  mul_res = prod_uu[XLEN-1:0];
        endcase
    end

    assign result_o = m_valid_i ? mul_res : alu_res;

endmodule

`default_nettype wire

// ==== logic/exec_slice.sv ====
`default_nettype none

module exec_slice (
    input  logic                   CLK,
    input  logic                   reset_i,
    input  logic                   instr_valid_i,
    input  logic [31:0]            instr_i,
    output logic                   instr_ready_o,
    output logic                   retire_valid_o,
    input  logic                   retire_ready_i,
    output rv32_exec_pkg::retire_t retire_o
);
    import rv32_exec_pkg::*;

    decode_t         dec;
    m_op_e           m_op;
    logic            m_claim;
    logic            accept;
    logic            rf_wen;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] wb_data;
    retire_t         retire_d;
    retire_t         retire_q;
    logic            retire_valid_q;

    // Free when empty or when the held record leaves this cycle
    assign instr_ready_o = !retire_valid_q || retire_ready_i;
    assign accept        = instr_valid_i && instr_ready_o;

    rv32m_decode rv32m_decode_i (
        .instr_i (instr_i),
        .claim_o (m_claim),
        .m_op_o  (m_op)
    );

    control_unit control_unit_i (
        .instr_i   (instr_i),
        .m_claim_i (m_claim),
        .m_op_i    (m_op),
        .dec_o     (dec)
    );

    // Loads compute an address only and never write back
    assign rf_wen = accept && dec.wen && !dec.flags.load;

    reg_file reg_file_i (
        .CLK      (CLK),
        .reset_i  (reset_i),
        .rs1_i    (dec.rs1),
        .rs2_i    (dec.rs2),
        .rd_i     (dec.rd),
        .wen_i    (rf_wen),
        .wdata_i  (wb_data),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    always_comb begin
        case (dec.a_sel)
            A_RS1:   op_a = rs1_data;
            A_PC:    op_a = pc_q;
            default: op_a = '0;
        endcase
    end

    assign op_b = (dec.b_sel == B_IMM) ? dec.imm : rs2_data;

    alu alu_i (
        .a_i       (op_a),
        .b_i       (op_b),
        .alu_op_i  (dec.alu_op),
        .m_valid_i (dec.m_valid),
        .m_op_i    (dec.m_op),
        .result_o  (alu_res)
    );

    assign link = pc_q + XLEN'(PC_STEP);

    always_comb begin
        case (dec.wb_sel)
            WB_LINK: wb_data = link;
            WB_IMM:  wb_data = dec.imm;
            default: wb_data = alu_res;
        endcase
    end

    always_comb begin
        retire_d.pc    = pc_q;
        retire_d.rd    = dec.rd;
        retire_d.wen   = dec.wen && !dec.flags.load;
        retire_d.wdata = wb_data;
        retire_d.flags = dec.flags;
    end

    // Counter and record valid
    always_ff @(posedge CLK) begin
        if (reset_i) begin
            pc_q           <= '0;
            retire_valid_q <= 1'b0;
        end else if (accept) begin
            pc_q           <= link;
            retire_valid_q <= 1'b1;
        end else if (retire_ready_i) begin
            retire_valid_q <= 1'b0;
        end
    end

    // Record payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            retire_q <= retire_d;
        end
    end

    assign retire_valid_o = retire_valid_q;
    assign retire_o       = retire_q;

    // Back-pressure keeps the record intact
    a_hold_stable: assert property (
        @(posedge CLK) disable iff (reset_i)
        retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_o)
    );

    a_reset_quiet: assert property (
        @(posedge CLK) reset_i |=> !retire_valid_o
    );

endmodule

`default_nettype wire

// ==== dv/exec_slice_tb.sv ====
`default_nettype none

module exec_slice_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv32_exec_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 2;
    localparam logic [31:0] SEED = 32'h67e093ef;

    // Instructions issued by each test
    localparam int N_SEED = 62;
    localparam int N_ARITH = 80;
    localparam int N_X0 = 2;
    localparam int N_MUL = 40;
    localparam int N_DIV = 8;
    localparam int N_UPPER = 16;
    localparam int N_MEM = 24;
    localparam int N_SYS = 12;
    localparam int N_BP = 120;
    localparam int N_TOTAL = N_SEED + N_ARITH + N_X0 + N_MUL + N_DIV + N_UPPER + N_MEM
                           + N_SYS + N_BP;
    localparam longint TIMEOUT_NS = (20 * N_TOTAL + RESET_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        reset_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        instr_ready_o;
    logic        retire_valid_o;
    logic        retire_ready_i;
    retire_t     retire_o;

    // Reference model state
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    retire_t     exp_q[$];
    string       name_q[$];

    string   current_test;
    int      errors;
    int      checks;
    int      tests_run;
    int      issued;
    int      retired;
    int      test_errs;
    int      test_instrs;
    int      outstanding;
    logic    backpressure;
    logic    hold_pending;
    retire_t held_rec;

    exec_slice exec_slice_i (
        .CLK            (clk),
        .reset_i        (reset_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i),
        .retire_o       (retire_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Standard RV32I integer result
    function automatic logic [31:0] arith(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b, input logic alt_add,
                                          input logic alt_shift);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt_add ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt_shift) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // Product word picked by funct3 of MUL, MULH, MULHSU, MULHU
    function automatic logic [31:0] mul_word(input logic [1:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
        longint sa;
        longint sb;
        longint ua;
        longint ub;
        logic [63:0] p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = longint'({32'b0, a});
        ub = longint'({32'b0, b});
        case (f3)
            2'd0: p = ua * ub;
            2'd1: p = sa * sb;
            2'd2: p = sa * ub;
            default: p = ua * ub;
        endcase
        return (f3 == 2'd0) ? p[31:0] : p[63:32];
    endfunction

    function automatic retire_t predict(input logic [31:0] instr, input logic [31:0] regs [32],
                                        input logic [31:0] pc);
        retire_t     r;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_u;
        logic [2:0]  f3;
        logic [6:0]  f7;
        rs1v = regs[instr[19:15]];
        rs2v = regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_u = {instr[31:12], 12'b0};
        f3 = instr[14:12];
        f7 = instr[31:25];
        r = '0;
        r.pc = pc;
        r.rd = instr[11:7];
        case (instr[6:0])
            7'b0110111: begin
                r.wen = 1'b1;
                r.wdata = imm_u;
            end
            7'b0010111: begin
                r.wen = 1'b1;
                r.wdata = pc + imm_u;
            end
            7'b1101111, 7'b1100111: begin
                r.wen = 1'b1;
                r.wdata = pc + 32'd4;
                r.flags.jump = 1'b1;
            end
            7'b1100011: r.flags.branch = 1'b1;
            7'b0000011: begin
                r.wdata = rs1v + imm_i;
                r.flags.load = 1'b1;
            end
            7'b0100011: begin
                r.wdata = rs1v + imm_s;
                r.flags.store = 1'b1;
            end
            7'b0010011: begin
                r.wen = 1'b1;
                r.wdata = arith(f3, rs1v, imm_i, 1'b0, instr[30]);
            end
            7'b0110011: begin
                if (f7 == 7'h01 && !f3[2]) begin
                    r.wen = 1'b1;
                    r.wdata = mul_word(f3[1:0], rs1v, rs2v);
                end else if (f7 == 7'h01) begin
                    r.flags.illegal = 1'b1;
                end else begin
                    r.wen = 1'b1;
                    r.wdata = arith(f3, rs1v, rs2v, instr[30], instr[30]);
                end
            end
            7'b0001111: ;
            7'b1110011: begin
                if (f3 != 3'd0) begin
                    r.flags.csr = 1'b1;
                end else begin
                    case (instr[31:20])
                        12'h000: r.flags.ecall = 1'b1;
                        12'h001: r.flags.ebreak = 1'b1;
                        12'h302: r.flags.mret = 1'b1;
                        12'h105: r.flags.wfi = 1'b1;
                        default: ;
                    endcase
                end
            end
            default: r.flags.illegal = 1'b1;
        endcase
        return r;
    endfunction

    // No value is written and no address reported, so wdata is free
    function automatic retire_t visible(input retire_t r);
        retire_t v;
        v = r;
        if (!v.wen && !v.flags.load && !v.flags.store) begin
            v.wdata = '0;
        end
        return v;
    endfunction

    task automatic check_retire(input string name, input retire_t exp, input retire_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h actual %h (pc %h)", name, exp, act, exp.pc);
        end
    endtask

    task automatic check_flag(input string name, input string flag, input logic exp,
                              input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %b actual %b", name, flag, exp, act);
        end
    endtask

    // Mostly nonzero, now and then x0
    function automatic logic [4:0] rand_rd();
        if ($urandom % 8 == 0) begin
            return 5'd0;
        end
        return 5'(1 + $urandom % 31);
    endfunction

    function automatic logic [31:0] gen_arith();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        rd = rand_rd();
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        f3 = 3'($urandom);
        alt = 1'($urandom);
        imm = 12'($urandom);
        if ($urandom % 2 == 0) begin
            return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd,
                    7'b0110011};
        end
        if (f3 == 3'd1) begin
            imm = {7'h00, imm[4:0]};
        end else if (f3 == 3'd5) begin
            imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
        end
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] gen_muldiv(input logic div);
        return {7'h01, 5'($urandom), 5'($urandom), div, 2'($urandom), rand_rd(), 7'b0110011};
    endfunction

    function automatic logic [31:0] gen_upper(input int kind);
        case (kind)
            0: return {20'($urandom), rand_rd(), 7'b0110111};
            1: return {20'($urandom), rand_rd(), 7'b0010111};
            2: return {20'($urandom), rand_rd(), 7'b1101111};
            default: return {12'($urandom), 5'($urandom), 3'b000, rand_rd(), 7'b1100111};
        endcase
    endfunction

    function automatic logic [31:0] gen_mem(input int kind);
        int         pick;
        logic [2:0] f3;
        pick = $urandom % 6;
        case (kind)
            0: begin
                // LB, LH, LW, LBU, LHU
                f3 = 3'((pick % 5 < 3) ? pick % 5 : pick % 5 + 1);
                return {12'($urandom), 5'($urandom), f3, rand_rd(), 7'b0000011};
            end
            1: begin
                f3 = 3'(pick % 3);
                return {7'($urandom), 5'($urandom), 5'($urandom), f3, 5'($urandom), 7'b0100011};
            end
            default: begin
                f3 = 3'((pick < 2) ? pick : pick + 2);
                return {7'($urandom), 5'($urandom), 5'($urandom), f3, 5'($urandom), 7'b1100011};
            end
        endcase
    endfunction

    function automatic logic [31:0] gen_system(input int kind);
        int         pick;
        logic [6:0] opc;
        pick = $urandom % 6;
        case (kind)
            0: return 32'h0000_0073;
            1: return 32'h0010_0073;
            2: return 32'h3020_0073;
            3: return 32'h1050_0073;
            4: return {12'($urandom), 5'($urandom), 3'((pick < 3) ? pick + 1 : pick + 2),
                       rand_rd(), 7'b1110011};
            default: begin
                // AMO, OP-FP, LOAD-FP and an all-ones opcode
                case (pick % 4)
                    0: opc = 7'b0101111;
                    1: opc = 7'b1010011;
                    2: opc = 7'b0000111;
                    default: opc = 7'b1111111;
                endcase
                return {25'($urandom), opc};
            end
        endcase
    endfunction

    function automatic logic [31:0] gen_any();
        case ($urandom % 6)
            0: return gen_arith();
            1: return gen_muldiv(1'($urandom % 4 == 0));
            2: return gen_upper($urandom % 4);
            3: return gen_mem($urandom % 3);
            4: return gen_system($urandom % 6);
            default: return gen_arith();
        endcase
    endfunction

    // Drive one instruction, wait for acceptance, then queue its expected record
    task automatic issue(input logic [31:0] instr);
        retire_t exp;
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i = instr;
        do begin
            @(posedge clk);
        end while (!instr_ready_o);
        exp = predict(instr, model_regs, model_pc);
        exp_q.push_back(exp);
        name_q.push_back(current_test);
        if (exp.wen && exp.rd != 5'd0) begin
            model_regs[exp.rd] = exp.wdata;
        end
        model_pc = model_pc + 32'd4;
        issued++;
        test_instrs++;
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errs = errors;
        test_instrs = 0;
    endtask

    task automatic finish_test();
        @(negedge clk);
        instr_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        tests_run++;
        $display("test %-10s %0d instructions, %0d errors", current_test, test_instrs,
                 errors - test_errs);
    endtask

    // Random back-pressure only while enabled
    always @(negedge clk) begin
        retire_ready_i = backpressure ? 1'($urandom % 2) : 1'b1;
    end

    // Compare process
    always @(posedge clk) begin
        retire_t exp;
        string   name;
        if (!reset_i) begin
            // One record slot, filled one cycle after acceptance
            check_flag(current_test, "retire_valid", outstanding != 0, retire_valid_o);
            check_flag(current_test, "instr_ready", outstanding == 0 || retire_ready_i,
                       instr_ready_o);
            if (hold_pending) begin
                if (!retire_valid_o) begin
                    errors++;
                    $display("Held record was dropped before it was taken");
                end else if (retire_o !== held_rec) begin
                    errors++;
                    $display("CHECK FAILED %s held record: expected %h actual %h",
                             current_test, held_rec, retire_o);
                end
            end
            if (retire_valid_o && retire_ready_i) begin
                retired++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("A record retired with no instruction outstanding");
                end else begin
                    exp = exp_q.pop_front();
                    name = name_q.pop_front();
                    check_retire(name, visible(exp), visible(retire_o));
                    check_flag(name, "illegal", exp.flags.illegal, retire_o.flags.illegal);
                    if (exp.flags != '0) begin
                        check_flag(name, "single flag", 1'b1, $onehot(retire_o.flags));
                    end
                end
            end
            if (instr_valid_i && instr_ready_o) begin
                outstanding++;
            end
            if (retire_valid_o && retire_ready_i) begin
                outstanding--;
            end
            hold_pending = retire_valid_o && !retire_ready_i;
            held_rec = retire_o;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns with %0d records outstanding", TIMEOUT_NS,
                 exp_q.size());
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        reset_i = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = '0;
        retire_ready_i = 1'b1;
        backpressure = 1'b0;
        hold_pending = 1'b0;
        outstanding = 0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        issued = 0;
        retired = 0;
        model_pc = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // Fill x1..x31 with random values
        start_test("seed");
        for (int r = 1; r < 32; r++) begin
            issue({20'($urandom), 5'(r), 7'b0110111});
            issue({12'($urandom), 5'(r), 3'b000, 5'(r), 7'b0010011});
        end
        finish_test();

        start_test("arith");
        repeat (N_ARITH) issue(gen_arith());
        finish_test();

        // ADDI x0 then ADD x1, x0, x0
        start_test("x0");
        issue({12'd123, 5'd5, 3'b000, 5'd0, 7'b0010011});
        issue({7'h00, 5'd0, 5'd0, 3'b000, 5'd1, 7'b0110011});
        finish_test();

        start_test("muldiv");
        repeat (N_MUL) issue(gen_muldiv(1'b0));
        repeat (N_DIV) issue(gen_muldiv(1'b1));
        finish_test();

        start_test("upper");
        for (int i = 0; i < N_UPPER; i++) begin
            issue(gen_upper(i % 4));
        end
        finish_test();

        start_test("mem");
        for (int i = 0; i < N_MEM; i++) begin
            issue(gen_mem(i % 3));
        end
        finish_test();

        start_test("system");
        for (int i = 0; i < N_SYS; i++) begin
            issue(gen_system((i < 4) ? i : 4 + (i % 2)));
        end
        finish_test();

        start_test("backpress");
        backpressure = 1'b1;
        repeat (N_BP) issue(gen_any());
        finish_test();
        backpressure = 1'b0;

        if (retired != issued) begin
            errors++;
            $display("Issued %0d instructions but %0d records retired", issued, retired);
        end
        $display("summary: %0d tests, %0d instructions, %0d checks, %0d errors", tests_run,
                 issued, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/rv32_exec_pkg.sv
logic/control_unit.sv
logic/rv32m_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/exec_slice.sv
dv/exec_slice_tb.sv

// ==== Bender.yml ====
package:
  name: exec_slice

sources:
  - logic/rv32_exec_pkg.sv
  - logic/control_unit.sv
  - logic/rv32m_decode.sv
  - logic/reg_file.sv
  - logic/alu.sv
  - logic/exec_slice.sv
  - target: test
    files:
      - dv/exec_slice_tb.sv
